// File: vlog.f
+incdir+logic
logic/mig_pkg.sv
logic/host_cmd_decoder.sv
logic/dram_column_queue.sv
logic/dram_port_arbiter.sv
logic/led_status.sv
logic/mig_bridge_top.sv
test/mig_bridge_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := mig_bridge_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/mig_bridge_tb.sv
/*
  Testbench for the DRAM request bridge, BREATH_TICKS set to 20.
  Random stimulus from a fixed seed. A DRAM model answers reads in order.
  Expected DRAM traffic is tracked per column, since columns may reorder.
  Reads only target addresses that were written earlier.
*/
`timescale 1ns/1ps
`include "mig_defs.svh"

module mig_bridge_tb
  import mig_pkg::*;
();

  localparam int TIMEOUT = 3000;

  logic       mig_clk;
  logic       mig_reset;
  logic       host_v_i;
  mig_op_e    host_op_i;
  addr_t      host_addr_i;
  data_t      host_wdata_i;
  logic       host_ready_o;
  logic       host_err_o;
  logic       dram_v_o;
  mig_op_e    dram_op_o;
  dram_addr_t dram_addr_o;
  data_t      dram_wdata_o;
  logic       dram_ready_i;
  logic       dram_rvalid_i;
  data_t      dram_rdata_i;
  dram_addr_t dram_raddr_i;
  logic       host_rvalid_o;
  data_t      host_rdata_o;
  addr_t      host_raddr_o;
  logic [7:0] led_o;

  integer seed;
  int     error_cnt = 0;
  int     check_cnt = 0;
  int     tests_run = 0;
  int     test_checks0 = 0;
  int     test_errors0 = 0;
  int     accept_cnt = 0;
  int     dram_req_cnt = 0;
  int     err_pulses = 0;
  int     stall_cnt = 0;
  int     busy_checks = 0;
  int     t_hist1 = 0;
  int     t_hist2 = 0;
  int     bp_cnt = 0;
  int     rd_gap = 0;
  logic   bp_mode = 1'b0;
  logic   busy_watch = 1'b0;
  logic   err_due = 1'b0;

  // expected commands per column in arrival order
  addr_t      exp_addr [`MIG_NUM_COLS][$];
  mig_op_e    exp_op   [`MIG_NUM_COLS][$];
  data_t      exp_data [`MIG_NUM_COLS][$];
  addr_t      ret_addr_q[$];
  data_t      ret_data_q[$];
  dram_addr_t rd_addr_q[$];
  data_t      rd_data_q[$];
  data_t      ref_mem  [addr_t];
  data_t      dram_mem [dram_addr_t];
  addr_t      written_q[$];

  mig_bridge_top #(.BREATH_TICKS(20)) u_mig_bridge_top (.*);

  always #20 mig_clk = !mig_clk;

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic addr_t rand_win_addr();
    addr_t hi;
    addr_t lo;
    hi = rand_word() & 32'h0ff0_0000;
    lo = (rand_word() & 32'h0000_003f) << 2;
    rand_win_addr = `MIG_DRAM_BASE | hi | lo;
  endfunction

  function automatic logic in_window(input addr_t a);
    in_window = (a >= `MIG_DRAM_BASE) && (a < `MIG_DRAM_HIGH);
  endfunction

  function automatic int pending_total();
    int n;
    n = 0;
    for (int c = 0; c < `MIG_NUM_COLS; c++)
      n += exp_addr[c].size();
    pending_total = n;
  endfunction

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    check_cnt++;
    if (got !== exp)
    begin
      error_cnt++;
      $display("CHECK FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ------------------------------
  // host side
  task automatic send_cmd(input mig_op_e op, input addr_t addr, input data_t data);
    int waited;
    host_v_i     = 1'b1;
    host_op_i    = op;
    host_addr_i  = addr;
    host_wdata_i = data;
    waited       = 0;
    @(negedge mig_clk);
    if (!host_ready_o)
      stall_cnt++;
    while (!host_ready_o && waited < TIMEOUT)
    begin
      waited++;
      @(negedge mig_clk);
    end
    if (!host_ready_o)
    begin
      error_cnt++;
      $display("host command to %h was never accepted", addr);
    end
    else if (op == MIG_OP_WRITE && in_window(addr))
      written_q.push_back(addr);
    @(posedge mig_clk);
    #2;
    host_v_i = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while ((pending_total() != 0 || ret_addr_q.size() != 0) && waited < TIMEOUT)
    begin
      waited++;
      @(posedge mig_clk);
    end
    if (pending_total() != 0 || ret_addr_q.size() != 0)
    begin
      error_cnt++;
      $display("bridge did not drain its pending requests in time");
    end
    @(posedge mig_clk);
    #2;
  endtask

  task automatic end_test(input string name);
    $display("test %s done: %0d checks, %0d errors", name,
             check_cnt - test_checks0, error_cnt - test_errors0);
    tests_run++;
    test_checks0 = check_cnt;
    test_errors0 = error_cnt;
  endtask

  // ------------------------------
  // DRAM model driven after the edge
  always @(posedge mig_clk)
  begin : dram_driver
    #2;
    dram_rvalid_i = 1'b0;
    if (mig_reset)
    begin
      dram_ready_i = 1'b0;
      rd_gap       = 0;
    end
    else
    begin
      bp_cnt = (bp_cnt + 1) % 32;
      if (bp_mode)
        dram_ready_i = (bp_cnt < 3);
      else
        dram_ready_i = (rand_word() % 32'd4) != 0;
      if (rd_gap > 0)
        rd_gap--;
      else if (rd_addr_q.size() > 0)
      begin
        dram_rvalid_i = 1'b1;
        dram_raddr_i  = rd_addr_q.pop_front();
        dram_rdata_i  = rd_data_q.pop_front();
        rd_gap        = int'(rand_word() % 32'd4);
      end
    end
  end

  // ------------------------------
  // monitor sampled mid-cycle
  always @(negedge mig_clk)
  begin : monitor
    int c;
    if (!mig_reset)
    begin
      // two cycles of lag from queue state to led_o[1]
      if (busy_watch && t_hist2 >= 2)
      begin
        compare_value(32'(led_o[1]), 32'd1, "busy LED with requests queued");
        busy_checks++;
      end
      if (host_err_o || err_due)
        compare_value(32'(host_err_o), 32'(err_due), "host_err_o pulse");
      if (host_err_o)
        err_pulses++;
      err_due = 1'b0;

      if (dram_v_o && dram_ready_i)
      begin
        dram_req_cnt++;
        c = int'(dram_addr_o[`MIG_COL_LSB +: 2]);
        if (exp_addr[c].size() == 0)
        begin
          error_cnt++;
          $display("DRAM request to %h has no matching host command", dram_addr_o);
        end
        else
        begin
          compare_value(32'(dram_addr_o), 32'(dram_addr_t'(exp_addr[c][0] ^ `MIG_DRAM_BASE)),
                        "DRAM address");
          compare_value(32'(dram_op_o), 32'(exp_op[c][0]), "DRAM op");
          if (dram_op_o == MIG_OP_WRITE)
          begin
            compare_value(dram_wdata_o, exp_data[c][0], "DRAM write data");
            dram_mem[dram_addr_o] = dram_wdata_o;
          end
          else
          begin
            rd_addr_q.push_back(dram_addr_o);
            if (dram_mem.exists(dram_addr_o))
              rd_data_q.push_back(dram_mem[dram_addr_o]);
            else
              rd_data_q.push_back('0);
            ret_addr_q.push_back(exp_addr[c][0]);
            ret_data_q.push_back(exp_data[c][0]);
          end
          void'(exp_addr[c].pop_front());
          void'(exp_op[c].pop_front());
          void'(exp_data[c].pop_front());
        end
      end

      if (host_rvalid_o)
      begin
        if (ret_addr_q.size() == 0)
        begin
          error_cnt++;
          $display("read response arrived with no read outstanding");
        end
        else
        begin
          compare_value(host_raddr_o, ret_addr_q.pop_front(), "host read address");
          compare_value(host_rdata_o, ret_data_q.pop_front(), "host read data");
        end
      end

      if (host_v_i && host_ready_o)
      begin
        if (in_window(host_addr_i))
        begin
          c = int'(host_addr_i[`MIG_COL_LSB +: 2]);
          accept_cnt++;
          if (host_op_i == MIG_OP_WRITE)
            ref_mem[host_addr_i] = host_wdata_i;
          exp_addr[c].push_back(host_addr_i);
          exp_op[c].push_back(host_op_i);
          if (ref_mem.exists(host_addr_i))
            exp_data[c].push_back(ref_mem[host_addr_i]);
          else
            exp_data[c].push_back('0);
        end
        else
          err_due = 1'b1;
      end
      t_hist2 = t_hist1;
      t_hist1 = pending_total();
    end
  end

  // ------------------------------
  // test sequence
  initial
  begin : main
    logic  prev_led;
    int    gap;
    int    idx;
    int    base_req;
    int    base_acc;
    addr_t a;
    seed          = 32'h79c256e0;
    mig_clk       = 1'b0;
    mig_reset     = 1'b1;
    host_v_i      = 1'b0;
    host_op_i     = MIG_OP_READ;
    host_addr_i   = '0;
    host_wdata_i  = '0;
    dram_ready_i  = 1'b0;
    dram_rvalid_i = 1'b0;
    dram_rdata_i  = '0;
    dram_raddr_i  = '0;
    repeat (8) @(posedge mig_clk);
    #2;
    mig_reset = 1'b0;

    @(negedge mig_clk);
    compare_value(32'(dram_v_o), 32'd0, "dram_v_o after reset");
    compare_value(32'(host_rvalid_o), 32'd0, "host_rvalid_o after reset");
    compare_value(32'(host_err_o), 32'd0, "host_err_o after reset");
    compare_value(32'(led_o), 32'd0, "led_o after reset");
    for (int n = 0; n < 3; n++)
    begin
      prev_led = led_o[0];
      gap      = 1;
      @(negedge mig_clk);
      while (led_o[0] == prev_led && gap < 100)
      begin
        gap++;
        @(negedge mig_clk);
      end
      if (n > 0)
        compare_value(32'(gap), 32'd21, "breathing LED period");
    end
    @(posedge mig_clk);
    #2;
    end_test("reset");

    for (int i = 0; i < 16; i++)
      send_cmd(MIG_OP_WRITE, rand_win_addr(), rand_word());
    wait_idle();
    end_test("translation");

    for (int i = 0; i < 24; i++)
      send_cmd(MIG_OP_WRITE, rand_win_addr(), rand_word());
    for (int i = 0; i < 24; i++)
    begin
      idx = int'(rand_word() % 32'(written_q.size()));
      send_cmd(MIG_OP_READ, written_q[idx], rand_word());
    end
    wait_idle();
    end_test("read-back");

    for (int i = 0; i < 8; i++)
    begin
      a = rand_win_addr();
      send_cmd(MIG_OP_WRITE, a, rand_word());
      send_cmd(MIG_OP_READ, a, '0);
    end
    wait_idle();
    end_test("same-address");

    base_req   = dram_req_cnt;
    err_pulses = 0;
    compare_value(32'(led_o[2]), 32'd0, "error LED before bad commands");
    for (int i = 0; i < 6; i++)
    begin
      if (i % 2 == 0)
        a = rand_word() & 32'h7fff_fffc;
      else
        a = `MIG_DRAM_HIGH + (rand_word() & 32'h6fff_fffc);
      send_cmd((i < 3) ? MIG_OP_WRITE : MIG_OP_READ, a, rand_word());
    end
    repeat (3) @(posedge mig_clk);
    #2;
    compare_value(32'(err_pulses), 32'd6, "host_err_o pulse count");
    compare_value(32'(led_o[2]), 32'd1, "error LED after bad commands");
    repeat (10) @(posedge mig_clk);
    #2;
    compare_value(32'(led_o[2]), 32'd1, "error LED stays set");
    compare_value(32'(dram_req_cnt), 32'(base_req), "no DRAM request for bad commands");
    end_test("out-of-window");

    // long ready-low stretches
    bp_mode     = 1'b1;
    busy_watch  = 1'b1;
    stall_cnt   = 0;
    busy_checks = 0;
    base_req    = dram_req_cnt;
    base_acc    = accept_cnt;
    for (int i = 0; i < 40; i++)
    begin
      if (rand_word() % 32'd2 == 0)
      begin
        idx = int'(rand_word() % 32'(written_q.size()));
        send_cmd(MIG_OP_READ, written_q[idx], '0);
      end
      else
        send_cmd(MIG_OP_WRITE, rand_win_addr(), rand_word());
    end
    bp_mode = 1'b0;
    wait_idle();
    busy_watch = 1'b0;
    compare_value(32'(stall_cnt > 0), 32'd1, "host_ready_o fell under back-pressure");
    compare_value(32'(busy_checks > 0), 32'd1, "busy LED was sampled");
    compare_value(32'(led_o[1]), 32'd0, "busy LED after drain");
    compare_value(32'(dram_req_cnt - base_req), 32'(accept_cnt - base_acc),
                  "DRAM requests against accepted commands");
    end_test("back-pressure");

    $display("tests %0d, checks %0d, errors %0d", tests_run, check_cnt, error_cnt);
    if (error_cnt == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: logic/mig_bridge_top.sv
/*
  DRAM request bridge top. Host commands go through the window check into four
  column queues, then a round-robin arbiter puts them on one DRAM port.
  Only reads get a response. Order holds per address, not across columns.
*/
`timescale 1ns/1ps
`include "mig_defs.svh"

module mig_bridge_top
  import mig_pkg::*;
#(
  parameter int unsigned BREATH_TICKS = `MIG_BREATH_TICKS
)
(
  input  logic       mig_clk,
  input  logic       mig_reset,
  input  logic       host_v_i,
  input  mig_op_e    host_op_i,
  input  addr_t      host_addr_i,
  input  data_t      host_wdata_i,
  output logic       host_ready_o,
  output logic       host_err_o,
  output logic       dram_v_o,
  output mig_op_e    dram_op_o,
  output dram_addr_t dram_addr_o,
  output data_t      dram_wdata_o,
  input  logic       dram_ready_i,
  input  logic       dram_rvalid_i,
  input  data_t      dram_rdata_i,
  input  dram_addr_t dram_raddr_i,
  output logic       host_rvalid_o,
  output data_t      host_rdata_o,
  output addr_t      host_raddr_o,
  output logic [7:0] led_o
);

  logic [`MIG_NUM_COLS-1:0] col_push;
  logic [`MIG_NUM_COLS-1:0] col_full;
  logic [`MIG_NUM_COLS-1:0] col_pop;
  logic [`MIG_NUM_COLS-1:0] col_v;
  mig_op_e                  col_op   [`MIG_NUM_COLS];
  addr_t                    col_addr [`MIG_NUM_COLS];
  data_t                    col_data [`MIG_NUM_COLS];
  logic                     busy;

  host_cmd_decoder u_host_cmd_decoder
  (
    .mig_clk      (mig_clk),
    .mig_reset    (mig_reset),
    .host_v_i     (host_v_i),
    .host_addr_i  (host_addr_i),
    .col_full_i   (col_full),
    .host_ready_o (host_ready_o),
    .col_push_o   (col_push),
    .host_err_o   (host_err_o)
  );

  // ------------------------------
  // column queues share the command fields
  for (genvar g = 0; g < `MIG_NUM_COLS; g++)
  begin : g_col
    dram_column_queue u_dram_column_queue
    (
      .mig_clk   (mig_clk),
      .mig_reset (mig_reset),
      .push_i    (col_push[g]),
      .op_i      (host_op_i),
      .addr_i    (host_addr_i),
      .data_i    (host_wdata_i),
      .pop_i     (col_pop[g]),
      .full_o    (col_full[g]),
      .v_o       (col_v[g]),
      .op_o      (col_op[g]),
      .addr_o    (col_addr[g]),
      .data_o    (col_data[g])
    );
  end

  dram_port_arbiter u_dram_port_arbiter
  (
    .mig_clk       (mig_clk),
    .mig_reset     (mig_reset),
    .col_v_i       (col_v),
    .col_op_i      (col_op),
    .col_addr_i    (col_addr),
    .col_data_i    (col_data),
    .col_pop_o     (col_pop),
    .dram_v_o      (dram_v_o),
    .dram_op_o     (dram_op_o),
    .dram_addr_o   (dram_addr_o),
    .dram_wdata_o  (dram_wdata_o),
    .dram_ready_i  (dram_ready_i),
    .dram_rvalid_i (dram_rvalid_i),
    .dram_rdata_i  (dram_rdata_i),
    .dram_raddr_i  (dram_raddr_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_raddr_o  (host_raddr_o)
  );

  // anything queued counts as busy
  assign busy = |col_v;

  led_status #(.BREATH_TICKS(BREATH_TICKS)) u_led_status
  (
    .mig_clk   (mig_clk),
    .mig_reset (mig_reset),
    .busy_i    (busy),
    .err_i     (host_err_o),
    .led_o     (led_o)
  );

endmodule

// File: logic/led_status.sv
/*
  Status LEDs. Bit 0 breathes, toggling every BREATH_TICKS+1 cycles.
  Bit 1 is busy, one cycle late. Bit 2 is a sticky error that only reset clears.
  Bits 7..3 are unused and stay low.
*/
`timescale 1ns/1ps
`include "mig_defs.svh"

module led_status
#(
  parameter int unsigned BREATH_TICKS = `MIG_BREATH_TICKS
)
(
  input  logic       mig_clk,
  input  logic       mig_reset,
  input  logic       busy_i,
  input  logic       err_i,
  output logic [7:0] led_o
);

  logic [31:0] breath_cnt_r;
  logic        breath_r;
  logic        busy_r;
  logic        err_sticky_r;

  always_ff @(posedge mig_clk)
  begin
    if (mig_reset)
    begin
      breath_cnt_r <= '0;
      breath_r     <= 1'b0;
      busy_r       <= 1'b0;
      err_sticky_r <= 1'b0;
    end
    else
    begin
      if (breath_cnt_r == BREATH_TICKS)
      begin
        breath_cnt_r <= '0;
        breath_r     <= !breath_r;
      end
      else
      begin
        breath_cnt_r <= breath_cnt_r + 1'b1;
      end
      busy_r       <= busy_i;
      err_sticky_r <= err_sticky_r || err_i;
    end
  end

  assign led_o = {5'b0, err_sticky_r, busy_r, breath_r};

endmodule

// File: logic/dram_port_arbiter.sv
/*
  Round-robin drain of the column queues onto the single DRAM port.
  The DRAM request is a register that refills in the cycle it transfers.
  DRAM addresses are host addresses with MIG_DRAM_BASE removed by XOR.
  Read returns have no back-pressure and reach the host one cycle later.
*/
`timescale 1ns/1ps
`include "mig_defs.svh"

module dram_port_arbiter
  import mig_pkg::*;
(
  input  logic                     mig_clk,
  input  logic                     mig_reset,
  input  logic [`MIG_NUM_COLS-1:0] col_v_i,
  input  mig_op_e                  col_op_i   [`MIG_NUM_COLS],
  input  addr_t                    col_addr_i [`MIG_NUM_COLS],
  input  data_t                    col_data_i [`MIG_NUM_COLS],
  output logic [`MIG_NUM_COLS-1:0] col_pop_o,
  output logic                     dram_v_o,
  output mig_op_e                  dram_op_o,
  output dram_addr_t               dram_addr_o,
  output data_t                    dram_wdata_o,
  input  logic                     dram_ready_i,
  input  logic                     dram_rvalid_i,
  input  data_t                    dram_rdata_i,
  input  dram_addr_t               dram_raddr_i,
  output logic                     host_rvalid_o,
  output data_t                    host_rdata_o,
  output addr_t                    host_raddr_o
);

  col_idx_t   rr_ptr_r;
  col_idx_t   grant_idx;
  logic       grant_found;
  logic       load;
  logic       dram_v_r;
  mig_op_e    dram_op_r;
  dram_addr_t dram_addr_r;
  data_t      dram_wdata_r;
  logic       rvalid_r;
  data_t      rdata_r;
  dram_addr_t raddr_r;

  // ------------------------------
  // round-robin grant
  always_comb
  begin : grant_search
    col_idx_t cand;
    grant_found = 1'b0;
    grant_idx   = rr_ptr_r;
    for (int k = 0; k < `MIG_NUM_COLS; k++)
    begin
      cand = col_idx_t'((int'(rr_ptr_r) + k) % `MIG_NUM_COLS);
      if (!grant_found && col_v_i[cand])
      begin
        grant_found = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  // refill when empty or draining this cycle
  assign load = grant_found && (!dram_v_r || dram_ready_i);

  always_comb
  begin
    col_pop_o = '0;
    if (load)
      col_pop_o[grant_idx] = 1'b1;
  end

  // ------------------------------
  // request register
  always_ff @(posedge mig_clk)
  begin
    if (mig_reset)
    begin
      rr_ptr_r <= '0;
      dram_v_r <= 1'b0;
    end
    else
    begin
      if (load)
      begin
        rr_ptr_r <= col_idx_t'((int'(grant_idx) + 1) % `MIG_NUM_COLS);
        dram_v_r <= 1'b1;
      end
      else if (dram_ready_i)
      begin
        dram_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge mig_clk)
  begin
    if (load)
    begin
      dram_op_r    <= col_op_i[grant_idx];
      dram_addr_r  <= dram_addr_t'(col_addr_i[grant_idx] ^ addr_t'(`MIG_DRAM_BASE));
      dram_wdata_r <= col_data_i[grant_idx];
    end
  end

  assign dram_v_o     = dram_v_r;
  assign dram_op_o    = dram_op_r;
  assign dram_addr_o  = dram_addr_r;
  assign dram_wdata_o = dram_wdata_r;

  // ------------------------------
  // read return
  always_ff @(posedge mig_clk)
  begin
    if (mig_reset)
      rvalid_r <= 1'b0;
    else
      rvalid_r <= dram_rvalid_i;
  end

  always_ff @(posedge mig_clk)
  begin
    if (dram_rvalid_i)
    begin
      rdata_r <= dram_rdata_i;
      raddr_r <= dram_raddr_i;
    end
  end

  assign host_rvalid_o = rvalid_r;
  assign host_rdata_o  = rdata_r;
  // base goes back on for the host
  assign host_raddr_o  = addr_t'(raddr_r) ^ addr_t'(`MIG_DRAM_BASE);

  a_req_hold: assert property (@(posedge mig_clk) disable iff (mig_reset)
    dram_v_o && !dram_ready_i |=> dram_v_o && $stable(dram_op_o)
      && $stable(dram_addr_o) && $stable(dram_wdata_o));

endmodule

// File: logic/dram_column_queue.sv
/*
  Request FIFO for one DRAM column, holding op, address and data.
  The head entry shows on v_o/op_o/addr_o/data_o on the edge after its push.
  Push and pop may happen in the same cycle. Depth must be a power of two.
*/
`timescale 1ns/1ps
`include "mig_defs.svh"

module dram_column_queue
  import mig_pkg::*;
(
  input  logic    mig_clk,
  input  logic    mig_reset,
  input  logic    push_i,
  input  mig_op_e op_i,
  input  addr_t   addr_i,
  input  data_t   data_i,
  input  logic    pop_i,
  output logic    full_o,
  output logic    v_o,
  output mig_op_e op_o,
  output addr_t   addr_o,
  output data_t   data_o
);

  localparam int PTR_W = $clog2(`MIG_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`MIG_QUEUE_DEPTH + 1);

  mig_op_e          op_mem   [`MIG_QUEUE_DEPTH];
  addr_t            addr_mem [`MIG_QUEUE_DEPTH];
  data_t            data_mem [`MIG_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;

  always_ff @(posedge mig_clk)
  begin
    if (mig_reset)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop_i)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      // simultaneous push and pop leaves the count alone
      if (push_i && !pop_i)
        count_r <= count_r + 1'b1;
      else if (pop_i && !push_i)
        count_r <= count_r - 1'b1;
    end
  end

  always_ff @(posedge mig_clk)
  begin
    if (push_i)
    begin
      op_mem[wr_ptr_r]   <= op_i;
      addr_mem[wr_ptr_r] <= addr_i;
      data_mem[wr_ptr_r] <= data_i;
    end
  end

  assign full_o = (count_r == CNT_W'(`MIG_QUEUE_DEPTH));
  assign v_o    = (count_r != '0);
  assign op_o   = op_mem[rd_ptr_r];
  assign addr_o = addr_mem[rd_ptr_r];
  assign data_o = data_mem[rd_ptr_r];

  // decoder must respect full and arbiter must respect valid
  a_no_push_full: assert property (@(posedge mig_clk) disable iff (mig_reset)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge mig_clk) disable iff (mig_reset)
    pop_i |-> v_o);

endmodule

// File: logic/host_cmd_decoder.sv
/*
  Host command decode. Checks the DRAM window and steers a command to its column.
  host_ready_o is combinational. It drops only for an in-window command whose
  column is full. Out-of-window commands are always taken and give one
  host_err_o cycle on the next edge.
*/
`timescale 1ns/1ps
`include "mig_defs.svh"

module host_cmd_decoder
  import mig_pkg::*;
(
  input  logic                     mig_clk,
  input  logic                     mig_reset,
  input  logic                     host_v_i,
  input  addr_t                    host_addr_i,
  input  logic [`MIG_NUM_COLS-1:0] col_full_i,
  output logic                     host_ready_o,
  output logic [`MIG_NUM_COLS-1:0] col_push_o,
  output logic                     host_err_o
);

  logic     in_window;
  logic     accept;
  col_idx_t col_sel;
  logic     host_err_r;

  assign in_window = (host_addr_i >= addr_t'(`MIG_DRAM_BASE))
                   && (host_addr_i < addr_t'(`MIG_DRAM_HIGH));
  assign col_sel   = host_addr_i[`MIG_COL_LSB +: 2];

  // bad addresses never wait on a queue
  assign host_ready_o = !in_window || !col_full_i[col_sel];
  assign accept       = host_v_i && host_ready_o;

  always_comb
  begin
    col_push_o = '0;
    if (accept && in_window)
    begin
      col_push_o[col_sel] = 1'b1;
    end
  end

  always_ff @(posedge mig_clk)
  begin
    if (mig_reset)
    begin
      host_err_r <= 1'b0;
    end
    else
    begin
      host_err_r <= accept && !in_window;
    end
  end

  assign host_err_o = host_err_r;

endmodule

// File: logic/mig_pkg.sv
/*
  Types shared by the bridge modules.
  Widths come from the `define header. Only the operation code is an enum.
*/
`include "mig_defs.svh"

package mig_pkg;

  // single-word command type
  typedef enum logic [0:0]
  {
    MIG_OP_READ  = 1'b0,
    MIG_OP_WRITE = 1'b1
  } mig_op_e;

  // host side address and data
  typedef logic [`MIG_ADDR_W-1:0]      addr_t;
  typedef logic [`MIG_DATA_W-1:0]      data_t;

  // DRAM side address, base already removed
  typedef logic [`MIG_DRAM_ADDR_W-1:0] dram_addr_t;

  // selects one of the column queues
  typedef logic [1:0]                  col_idx_t;

endpackage

// File: logic/mig_defs.svh
/*
  Bridge-wide widths, sizes and DRAM window.
  The window is [MIG_DRAM_BASE, MIG_DRAM_HIGH). Base translation is done by XOR,
  so MIG_DRAM_BASE must be aligned to the DRAM size.
  MIG_QUEUE_DEPTH must be a power of two. MIG_NUM_COLS must be 2**(column index width).
*/
`ifndef MIG_DEFS_SVH
`define MIG_DEFS_SVH

// ------------------------------
// datapath widths
`define MIG_ADDR_W        32
`define MIG_DATA_W        32
`define MIG_DRAM_ADDR_W   28

// ------------------------------
// column queues
`define MIG_NUM_COLS      4
// column index sits at host address bits [5:4]
`define MIG_COL_LSB       4
`define MIG_QUEUE_DEPTH   4

// ------------------------------
// DRAM window and status
`define MIG_DRAM_BASE     32'h8000_0000
`define MIG_DRAM_HIGH     32'h9000_0000
// about 4 Hz breathing at a 100 MHz mig_clk
`define MIG_BREATH_TICKS  12500000

`endif
